//--- bus_source_mux.sv
`timescale 1ns/1ps

module bus_source_mux (
  input  logic                                clk,
  input  logic                                rst_n,
  input  microcode_pkg::cycle_t               cycle,
  input  microcode_pkg::reg_sel_t             src_sel,
  input  regfile_pkg::imm_word_u              immed,
  input  logic [regfile_pkg::NIBBLE_W-1:0]    alu_result,
  input  logic [regfile_pkg::NIBBLE_W-1:0]    mem_rdata,
  input  logic [regfile_pkg::NIBBLE_W-1:0]    a,
  input  logic [regfile_pkg::NIBBLE_W-1:0]    b,
  input  logic [regfile_pkg::NIBBLE_W-1:0]    temp_a,
  input  logic [regfile_pkg::NIBBLE_W-1:0]    temp_b,
  input  logic [regfile_pkg::ADDR_W-1:0]      x,
  input  logic [regfile_pkg::ADDR_W-1:0]      y,
  input  logic [regfile_pkg::SP_W-1:0]        sp,
  input  logic [regfile_pkg::NIBBLE_W-1:0]    flags,
  output logic [regfile_pkg::NIBBLE_W-1:0]    bus_data,
  output logic                                bus_alu_flags
);

  import microcode_pkg::*;
  import regfile_pkg::*;

  reg_sel_t            src_eff;
  logic                write_phase;
  logic [NIBBLE_W-1:0] bus_next;
  logic [NIBBLE_W-1:0] bus_keep;

  assign write_phase = (cycle == CYC_WRITE);

  // Immediate addressed source comes from the pair view
  always_comb begin
    if (src_sel == REG_IMM_SRC) begin
      src_eff = pair_sel(immed.pair.src_code);
    end else begin
      src_eff = src_sel;
    end
  end

  // --------------------------------------------------
  // Source decode
  // --------------------------------------------------
  always_comb begin
    bus_next = '0;
    if (is_mem_sel(src_eff)) begin
      // RAM output, captured at the end of fetch
      bus_next = mem_rdata;
    end else begin
      case (src_eff)
        REG_A:         bus_next = a;
        REG_B:         bus_next = b;
        REG_TEMPA:     bus_next = temp_a;
        REG_TEMPB:     bus_next = temp_b;
        REG_XL:        bus_next = x[3:0];
        REG_XH:        bus_next = x[7:4];
        REG_XP:        bus_next = x[11:8];
        REG_YL:        bus_next = y[3:0];
        REG_YH:        bus_next = y[7:4];
        REG_YP:        bus_next = y[11:8];
        REG_SPL:       bus_next = sp[3:0];
        REG_SPH:       bus_next = sp[7:4];
        REG_FLAGS:     bus_next = flags;
        REG_IMML:      bus_next = immed.value[3:0];
        REG_IMMH:      bus_next = immed.value[7:4];
        REG_ALU:       bus_next = alu_result;
        REG_ALU_FLAGS: bus_next = alu_result;
        REG_ONE:       bus_next = 4'h1;
        default:       bus_next = '0;
      endcase
    end
  end

  // --------------------------------------------------
  // Bus keeper between write phases
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus_keep <= '0;
    end else if (write_phase) begin
      bus_keep <= bus_next;
    end
  end

  // Live value only while writing, last transfer otherwise
  assign bus_data      = write_phase ? bus_next : bus_keep;
  assign bus_alu_flags = write_phase && (src_eff == REG_ALU_FLAGS);

endmodule

//--- mem_addr_unit.sv
`timescale 1ns/1ps

module mem_addr_unit (
  input  microcode_pkg::reg_sel_t           src_sel,
  input  microcode_pkg::reg_sel_t           dst_sel,
  input  regfile_pkg::imm_word_u            immed,
  input  logic [regfile_pkg::ADDR_W-1:0]    x,
  input  logic [regfile_pkg::ADDR_W-1:0]    y,
  input  logic [regfile_pkg::SP_W-1:0]      sp,
  output logic [regfile_pkg::ADDR_W-1:0]    mem_addr
);

  import microcode_pkg::*;
  import regfile_pkg::*;

  reg_sel_t        src_eff;
  reg_sel_t        dst_eff;
  reg_sel_t        ref_sel;
  logic [SP_W-1:0] sp_dec;

  // Wraps inside the 8-bit stack page
  assign sp_dec = sp - 1'b1;

  always_comb begin
    if (src_sel == REG_IMM_SRC) begin
      src_eff = pair_sel(immed.pair.src_code);
    end else begin
      src_eff = src_sel;
    end
  end

  always_comb begin
    if (dst_sel == REG_IMM_DST) begin
      dst_eff = pair_sel(immed.pair.dst_code);
    end else begin
      dst_eff = dst_sel;
    end
  end

  // Source wins so the address holds over fetch and write
  always_comb begin
    if (is_mem_sel(src_eff)) begin
      ref_sel = src_eff;
    end else begin
      ref_sel = dst_eff;
    end
  end

  // --------------------------------------------------
  // Address per memory reference
  // --------------------------------------------------
  always_comb begin
    case (ref_sel)
      REG_MX:      mem_addr = x;
      REG_MY:      mem_addr = y;
      REG_MSP:     mem_addr = {{(ADDR_W - SP_W){1'b0}}, sp};
      REG_MSP_DEC: mem_addr = {{(ADDR_W - SP_W){1'b0}}, sp_dec};
      REG_MN:      mem_addr = {{(ADDR_W - 8){1'b0}}, immed.value};
      default:     mem_addr = '0;
    endcase
  end

endmodule

//--- microcode_pkg.sv
package microcode_pkg;

  // --------------------------------------------------
  // Microinstruction phase
  // --------------------------------------------------
  typedef enum logic [1:0] {
    CYC_NONE  = 2'd0,
    CYC_FETCH = 2'd1,
    CYC_WRITE = 2'd2
  } cycle_t;

  // --------------------------------------------------
  // Bus source and destination codes
  // --------------------------------------------------
  typedef enum logic [4:0] {
    REG_A         = 5'd0,
    REG_B         = 5'd1,
    REG_TEMPA     = 5'd2,
    REG_TEMPB     = 5'd3,
    REG_XL        = 5'd4,
    REG_XH        = 5'd5,
    REG_XP        = 5'd6,
    REG_YL        = 5'd7,
    REG_YH        = 5'd8,
    REG_YP        = 5'd9,
    REG_SPL       = 5'd10,
    REG_SPH       = 5'd11,
    REG_FLAGS     = 5'd12,
    REG_IMML      = 5'd13,
    REG_IMMH      = 5'd14,
    REG_ALU       = 5'd15,
    REG_ALU_FLAGS = 5'd16,
    REG_ONE       = 5'd17,
    // Memory references
    REG_MX        = 5'd18,
    REG_MY        = 5'd19,
    REG_MSP       = 5'd20,
    REG_MSP_DEC   = 5'd21,
    REG_MN        = 5'd22,
    // Resolved through the immediate byte
    REG_IMM_SRC   = 5'd23,
    REG_IMM_DST   = 5'd24
  } reg_sel_t;

  // End of microinstruction pointer update
  typedef enum logic [2:0] {
    INC_NONE = 3'd0,
    INC_X    = 3'd1,
    INC_Y    = 3'd2,
    INC_SP   = 3'd3,
    DEC_SP   = 3'd4
  } inc_sel_t;

  // True for selectors that reach external memory
  function automatic logic is_mem_sel(reg_sel_t sel);
    return sel inside {REG_MX, REG_MY, REG_MSP, REG_MSP_DEC, REG_MN};
  endfunction

endpackage

//--- reg_bank.sv
`timescale 1ns/1ps

module reg_bank #(
  parameter logic [regfile_pkg::SP_W-1:0] SP_RESET = '0
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  microcode_pkg::cycle_t             cycle,
  input  microcode_pkg::reg_sel_t           src_sel,
  input  microcode_pkg::reg_sel_t           dst_sel,
  input  microcode_pkg::inc_sel_t           inc_sel,
  input  regfile_pkg::imm_word_u            immed,
  input  logic [regfile_pkg::NIBBLE_W-1:0]  bus_data,
  input  logic                              bus_alu_flags,
  input  logic                              alu_zero,
  input  logic                              alu_carry,
  output logic [regfile_pkg::NIBBLE_W-1:0]  a,
  output logic [regfile_pkg::NIBBLE_W-1:0]  b,
  output logic [regfile_pkg::NIBBLE_W-1:0]  temp_a,
  output logic [regfile_pkg::NIBBLE_W-1:0]  temp_b,
  output logic [regfile_pkg::ADDR_W-1:0]    x,
  output logic [regfile_pkg::ADDR_W-1:0]    y,
  output logic [regfile_pkg::SP_W-1:0]      sp,
  output logic [regfile_pkg::NIBBLE_W-1:0]  flags,
  output logic                              mem_we,
  output logic [regfile_pkg::NIBBLE_W-1:0]  mem_wdata
);

  import microcode_pkg::*;
  import regfile_pkg::*;

  reg_sel_t            dst_eff;
  logic                write_phase;

  logic                carry;
  logic                zero;
  logic                decimal;
  logic                interrupt;

  logic [NIBBLE_W-1:0] a_nxt;
  logic [NIBBLE_W-1:0] b_nxt;
  logic [NIBBLE_W-1:0] temp_a_nxt;
  logic [NIBBLE_W-1:0] temp_b_nxt;
  logic [ADDR_W-1:0]   x_nxt;
  logic [ADDR_W-1:0]   y_nxt;
  logic [SP_W-1:0]     sp_nxt;
  logic                carry_nxt;
  logic                zero_nxt;
  logic                decimal_nxt;
  logic                interrupt_nxt;

  assign write_phase = (cycle == CYC_WRITE);

  always_comb begin
    if (dst_sel == REG_IMM_DST) begin
      dst_eff = pair_sel(immed.pair.dst_code);
    end else begin
      dst_eff = dst_sel;
    end
  end

  // --------------------------------------------------
  // Memory store
  // --------------------------------------------------
  assign mem_we    = write_phase && is_mem_sel(dst_eff);
  assign mem_wdata = bus_data;

  // --------------------------------------------------
  // Next state at the end of the write phase
  // --------------------------------------------------
  always_comb begin
    a_nxt         = a;
    b_nxt         = b;
    temp_a_nxt    = temp_a;
    temp_b_nxt    = temp_b;
    x_nxt         = x;
    y_nxt         = y;
    sp_nxt        = sp;
    carry_nxt     = carry;
    zero_nxt      = zero;
    decimal_nxt   = decimal;
    interrupt_nxt = interrupt;

    if (write_phase) begin
      case (dst_eff)
        REG_A:     a_nxt = bus_data;
        REG_B:     b_nxt = bus_data;
        REG_TEMPA: temp_a_nxt = bus_data;
        REG_TEMPB: temp_b_nxt = bus_data;
        REG_XL:    x_nxt[3:0] = bus_data;
        REG_XH:    x_nxt[7:4] = bus_data;
        REG_XP:    x_nxt[11:8] = bus_data;
        REG_YL:    y_nxt[3:0] = bus_data;
        REG_YH:    y_nxt[7:4] = bus_data;
        REG_YP:    y_nxt[11:8] = bus_data;
        REG_SPL:   sp_nxt[3:0] = bus_data;
        REG_SPH:   sp_nxt[7:4] = bus_data;
        REG_FLAGS: begin
          carry_nxt     = bus_data[FLAG_C];
          zero_nxt      = bus_data[FLAG_Z];
          decimal_nxt   = bus_data[FLAG_D];
          interrupt_nxt = bus_data[FLAG_I];
        end
        default: ;
      endcase

      // ALU flags only touch C and Z
      if (bus_alu_flags) begin
        carry_nxt = alu_carry;
        zero_nxt  = alu_zero;
      end

      // Pointer update after the nibble write
      case (inc_sel)
        INC_X:   x_nxt = x_nxt + 1'b1;
        INC_Y:   y_nxt = y_nxt + 1'b1;
        INC_SP:  sp_nxt = sp_nxt + 1'b1;
        DEC_SP:  sp_nxt = sp_nxt - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a         <= '0;
      b         <= '0;
      temp_a    <= '0;
      temp_b    <= '0;
      x         <= '0;
      y         <= '0;
      sp        <= SP_RESET;
      carry     <= 1'b0;
      zero      <= 1'b0;
      decimal   <= 1'b0;
      interrupt <= 1'b0;
    end else begin
      a         <= a_nxt;
      b         <= b_nxt;
      temp_a    <= temp_a_nxt;
      temp_b    <= temp_b_nxt;
      x         <= x_nxt;
      y         <= y_nxt;
      sp        <= sp_nxt;
      carry     <= carry_nxt;
      zero      <= zero_nxt;
      decimal   <= decimal_nxt;
      interrupt <= interrupt_nxt;
    end
  end

  // Flags nibble as seen on the bus
  always_comb begin
    flags         = '0;
    flags[FLAG_C] = carry;
    flags[FLAG_Z] = zero;
    flags[FLAG_D] = decimal;
    flags[FLAG_I] = interrupt;
  end

endmodule

//--- regfile_pkg.sv
package regfile_pkg;

  // --------------------------------------------------
  // Architectural widths
  // --------------------------------------------------
  localparam int NIBBLE_W = 4;
  localparam int ADDR_W   = 12;
  localparam int SP_W     = 8;

  // Bit positions inside the flags nibble
  localparam int FLAG_C = 0;
  localparam int FLAG_Z = 1;
  localparam int FLAG_D = 2;
  localparam int FLAG_I = 3;

  // Register pair codes of the immediate byte
  localparam logic [1:0] PAIR_A  = 2'b00;
  localparam logic [1:0] PAIR_B  = 2'b01;
  localparam logic [1:0] PAIR_MX = 2'b10;
  localparam logic [1:0] PAIR_MY = 2'b11;

  // Immediate byte, either a plain value or a source/destination pair
  typedef union packed {
    logic [7:0] value;
    struct packed {
      logic [3:0] rsvd;
      logic [1:0] dst_code;
      logic [1:0] src_code;
    } pair;
  } imm_word_u;

  // Maps a pair code onto the matching bus selector
  function automatic microcode_pkg::reg_sel_t pair_sel(logic [1:0] code);
    case (code)
      PAIR_A:  return microcode_pkg::REG_A;
      PAIR_B:  return microcode_pkg::REG_B;
      PAIR_MX: return microcode_pkg::REG_MX;
      default: return microcode_pkg::REG_MY;
    endcase
  endfunction

endpackage

//--- regs_tb.sv
`timescale 1ns/1ps

module regs_tb;

  import microcode_pkg::*;

  localparam logic [7:0] SP_RESET    = 8'h40;
  localparam int         FLAG_ROUNDS = 4;
  localparam int         PAIR_ROUNDS = 20;
  // Microinstructions per test group
  localparam int RESET_UOPS = 2;
  localparam int LOAD_UOPS  = 12 * 2;
  localparam int READ_UOPS  = 8;
  localparam int INC_UOPS   = 14;
  localparam int DEC_UOPS   = 4;
  localparam int FLAG_UOPS  = FLAG_ROUNDS * 8 + 2;
  localparam int PAIR_UOPS  = PAIR_ROUNDS * 3;
  localparam int TOTAL_UOPS = RESET_UOPS + LOAD_UOPS + READ_UOPS + INC_UOPS + DEC_UOPS
                              + FLAG_UOPS + PAIR_UOPS;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_UOPS + 50;

  logic        clk;
  logic        rst_n;
  cycle_t      cycle;
  reg_sel_t    src_sel;
  reg_sel_t    dst_sel;
  inc_sel_t    inc_sel;
  logic [3:0]  alu_result;
  logic        alu_zero;
  logic        alu_carry;
  logic [7:0]  immed;
  logic [3:0]  mem_rdata = 4'h0;
  logic [11:0] mem_addr;
  logic        mem_we;
  logic [3:0]  mem_wdata;

  logic [3:0]  mem [4096];
  logic [15:0] lfsr = 16'd38;
  int          cycle_count = 0;
  int          checks = 0;
  int          errors = 0;

  // Shadow register set and memory
  logic [3:0]  sh_a;
  logic [3:0]  sh_b;
  logic [3:0]  sh_ta;
  logic [3:0]  sh_tb;
  logic [3:0]  sh_flags;
  logic [11:0] sh_x;
  logic [11:0] sh_y;
  logic [7:0]  sh_sp;
  logic [3:0]  sh_mem [4096];
  logic [3:0]  alu_res_q;
  logic        alu_z_q;
  logic        alu_c_q;

  // Expected bus activity of the current microinstruction
  string       cur_name;
  logic        exp_used;
  logic [11:0] exp_addr;
  logic        exp_we;
  logic [3:0]  exp_wdata;

  reg_sel_t load_list [12] = '{REG_A, REG_B, REG_TEMPA, REG_TEMPB, REG_XL, REG_XH,
                               REG_XP, REG_YL, REG_YH, REG_YP, REG_SPL, REG_SPH};

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clock_gen (.clk(clk), .rst_n(rst_n));

  regs_top #(.SP_RESET(SP_RESET)) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cycle      (cycle),
    .src_sel    (src_sel),
    .dst_sel    (dst_sel),
    .inc_sel    (inc_sel),
    .alu_result (alu_result),
    .alu_zero   (alu_zero),
    .alu_carry  (alu_carry),
    .immed      (immed),
    .mem_rdata  (mem_rdata),
    .mem_addr   (mem_addr),
    .mem_we     (mem_we),
    .mem_wdata  (mem_wdata)
  );

  // Synchronous RAM with one cycle of read latency
  always @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr];
  end

  // --------------------------------------------------
  // Random bits and reference model
  // --------------------------------------------------
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    logic       fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[6:0], fb};
    end
    return r;
  endfunction

  // A=00, B=01, MX=10, MY=11
  function automatic reg_sel_t decode_pair(input logic [1:0] code);
    reg_sel_t sel;
    case (code)
      2'b00:   sel = REG_A;
      2'b01:   sel = REG_B;
      2'b10:   sel = REG_MX;
      default: sel = REG_MY;
    endcase
    return sel;
  endfunction

  function automatic void reference_step(input reg_sel_t src, input reg_sel_t dst,
      input inc_sel_t inc, input logic [7:0] imm, output logic addr_used,
      output logic [11:0] addr, output logic we, output logic [3:0] wdata);
    reg_sel_t   s;
    reg_sel_t   d;
    reg_sel_t   mref;
    logic       s_mem;
    logic       d_mem;
    logic [3:0] data;
    logic [7:0] sp_m1;
    s = (src == REG_IMM_SRC) ? decode_pair(imm[1:0]) : src;
    d = (dst == REG_IMM_DST) ? decode_pair(imm[3:2]) : dst;
    s_mem = s inside {REG_MX, REG_MY, REG_MSP, REG_MSP_DEC, REG_MN};
    d_mem = d inside {REG_MX, REG_MY, REG_MSP, REG_MSP_DEC, REG_MN};
    mref = s_mem ? s : d;
    sp_m1 = sh_sp - 8'd1;
    addr_used = 1'b1;
    case (mref)
      REG_MX:      addr = sh_x;
      REG_MY:      addr = sh_y;
      REG_MSP:     addr = {4'h0, sh_sp};
      REG_MSP_DEC: addr = {4'h0, sp_m1};
      REG_MN:      addr = {4'h0, imm};
      default: begin
        addr      = 12'h000;
        addr_used = 1'b0;
      end
    endcase
    case (s)
      REG_A:         data = sh_a;
      REG_B:         data = sh_b;
      REG_TEMPA:     data = sh_ta;
      REG_TEMPB:     data = sh_tb;
      REG_XL:        data = sh_x[3:0];
      REG_XH:        data = sh_x[7:4];
      REG_XP:        data = sh_x[11:8];
      REG_YL:        data = sh_y[3:0];
      REG_YH:        data = sh_y[7:4];
      REG_YP:        data = sh_y[11:8];
      REG_SPL:       data = sh_sp[3:0];
      REG_SPH:       data = sh_sp[7:4];
      REG_FLAGS:     data = sh_flags;
      REG_IMML:      data = imm[3:0];
      REG_IMMH:      data = imm[7:4];
      REG_ALU:       data = alu_res_q;
      REG_ALU_FLAGS: data = alu_res_q;
      REG_ONE:       data = 4'h1;
      default:       data = sh_mem[addr];
    endcase
    we    = d_mem;
    wdata = data;
    if (d_mem) begin
      sh_mem[addr] = data;
    end
    case (d)
      REG_A:     sh_a = data;
      REG_B:     sh_b = data;
      REG_TEMPA: sh_ta = data;
      REG_TEMPB: sh_tb = data;
      REG_XL:    sh_x[3:0] = data;
      REG_XH:    sh_x[7:4] = data;
      REG_XP:    sh_x[11:8] = data;
      REG_YL:    sh_y[3:0] = data;
      REG_YH:    sh_y[7:4] = data;
      REG_YP:    sh_y[11:8] = data;
      REG_SPL:   sh_sp[3:0] = data;
      REG_SPH:   sh_sp[7:4] = data;
      REG_FLAGS: sh_flags = data;
      default: ;
    endcase
    // Carry is bit 0, zero is bit 1
    if (s == REG_ALU_FLAGS) begin
      sh_flags[0] = alu_c_q;
      sh_flags[1] = alu_z_q;
    end
    case (inc)
      INC_X:   sh_x = sh_x + 12'd1;
      INC_Y:   sh_y = sh_y + 12'd1;
      INC_SP:  sh_sp = sh_sp + 8'd1;
      DEC_SP:  sh_sp = sh_sp - 8'd1;
      default: ;
    endcase
  endfunction

  // --------------------------------------------------
  // Checking and stimulus
  // --------------------------------------------------
  task automatic check_value(input string name, input string what,
      input logic [11:0] expected, input logic [11:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s %s: expected %h, actual %h", name, what, expected, actual);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && cycle == CYC_FETCH) begin
      check_value(cur_name, "mem_we", 12'h000, {11'h0, mem_we});
      if (exp_used) begin
        check_value(cur_name, "mem_addr", exp_addr, mem_addr);
      end
    end
    if (rst_n && cycle == CYC_WRITE) begin
      check_value(cur_name, "mem_we", {11'h0, exp_we}, {11'h0, mem_we});
      if (exp_we) begin
        check_value(cur_name, "mem_wdata", {8'h0, exp_wdata}, {8'h0, mem_wdata});
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // One microinstruction as fetch then write
  task automatic run_uop(input string name, input reg_sel_t src, input reg_sel_t dst,
      input inc_sel_t inc, input logic [7:0] imm);
    logic        used;
    logic [11:0] addr;
    logic        we;
    logic [3:0]  wdata;
    @(posedge clk);
    reference_step(src, dst, inc, imm, used, addr, we, wdata);
    cur_name  = name;
    exp_used  = used;
    exp_addr  = addr;
    exp_we    = we;
    exp_wdata = wdata;
    src_sel    <= src;
    dst_sel    <= dst;
    inc_sel    <= inc;
    immed      <= imm;
    alu_result <= alu_res_q;
    alu_zero   <= alu_z_q;
    alu_carry  <= alu_c_q;
    cycle      <= CYC_FETCH;
    @(posedge clk);
    cycle <= CYC_WRITE;
  endtask

  // Register value out to M(n)
  task automatic read_back(input string name, input reg_sel_t r);
    run_uop(name, r, REG_MN, INC_NONE, rand_bits(8));
  endtask

  task automatic load_nibble(input string name, input reg_sel_t r, input logic [3:0] n);
    run_uop(name, REG_IMML, r, INC_NONE, {4'h0, n});
  endtask

  initial begin
    logic [7:0]  r;
    logic [11:0] ai;
    cycle      = CYC_NONE;
    src_sel    = REG_A;
    dst_sel    = REG_A;
    inc_sel    = INC_NONE;
    immed      = 8'h00;
    alu_result = 4'h0;
    alu_zero   = 1'b0;
    alu_carry  = 1'b0;
    alu_res_q  = 4'h0;
    alu_z_q    = 1'b0;
    alu_c_q    = 1'b0;
    exp_used   = 1'b0;
    exp_addr   = 12'h000;
    exp_we     = 1'b0;
    exp_wdata  = 4'h0;
    cur_name   = "idle";
    {sh_a, sh_b, sh_ta, sh_tb, sh_flags} = '0;
    sh_x  = 12'h000;
    sh_y  = 12'h000;
    sh_sp = SP_RESET;
    for (int i = 0; i < 4096; i++) begin
      ai        = 12'(i);
      r         = rand_bits(4);
      mem[i]    = r[3:0] ^ ai[3:0] ^ ai[7:4] ^ ai[11:8];
      sh_mem[i] = mem[i];
    end
    wait (rst_n === 1'b1);

    read_back("reset sp", REG_SPL);
    read_back("reset sp", REG_SPH);
    for (int k = 0; k < 12; k++) begin
      r = rand_bits(8);
      run_uop($sformatf("load %s", load_list[k].name()), (k % 2 == 0) ? REG_IMML : REG_IMMH,
              load_list[k], INC_NONE, r);
      read_back($sformatf("load %s", load_list[k].name()), load_list[k]);
    end

    // Memory reads through each pointer
    run_uop("read mx", REG_MX, REG_A, INC_NONE, 8'h00);
    read_back("read mx", REG_A);
    run_uop("read my", REG_MY, REG_B, INC_NONE, 8'h00);
    read_back("read my", REG_B);
    run_uop("read msp", REG_MSP, REG_TEMPA, INC_NONE, 8'h00);
    read_back("read msp", REG_TEMPA);
    run_uop("read mn", REG_MN, REG_TEMPB, INC_NONE, rand_bits(8));
    read_back("read mn", REG_TEMPB);

    // Post-increment across nibble and width boundaries
    load_nibble("inc y", REG_YL, 4'hF);
    load_nibble("inc y", REG_YH, 4'hF);
    load_nibble("inc y", REG_YP, 4'h2);
    run_uop("inc y", REG_A, REG_MY, INC_Y, 8'h00);
    run_uop("inc y carry", REG_A, REG_MY, INC_NONE, 8'h00);
    load_nibble("inc x", REG_XL, 4'hF);
    load_nibble("inc x", REG_XH, 4'hF);
    load_nibble("inc x", REG_XP, 4'hF);
    run_uop("inc x", REG_B, REG_MX, INC_X, 8'h00);
    run_uop("inc x wrap", REG_B, REG_MX, INC_NONE, 8'h00);
    load_nibble("inc sp", REG_SPL, 4'hF);
    load_nibble("inc sp", REG_SPH, 4'hF);
    run_uop("inc sp", REG_TEMPA, REG_MSP, INC_SP, 8'h00);
    run_uop("inc sp wrap", REG_TEMPA, REG_MSP, INC_NONE, 8'h00);

    // Push style store leaves SP on the address used
    run_uop("dec sp", REG_A, REG_MSP_DEC, DEC_SP, 8'h00);
    read_back("dec sp", REG_SPL);
    read_back("dec sp", REG_SPH);
    run_uop("dec sp again", REG_B, REG_MSP_DEC, DEC_SP, 8'h00);

    for (int k = 0; k < FLAG_ROUNDS; k++) begin
      run_uop("flags load", REG_IMML, REG_FLAGS, INC_NONE, rand_bits(8));
      read_back("flags load", REG_FLAGS);
      r = rand_bits(6);
      alu_res_q = r[3:0];
      alu_z_q   = r[4];
      alu_c_q   = r[5];
      run_uop("alu flags", REG_ALU_FLAGS, REG_A, INC_NONE, 8'h00);
      read_back("alu flags", REG_FLAGS);
      read_back("alu flags", REG_A);
      r = rand_bits(6);
      alu_res_q = r[3:0];
      alu_z_q   = r[4];
      alu_c_q   = r[5];
      run_uop("alu no flags", REG_ALU, REG_B, INC_NONE, 8'h00);
      read_back("alu no flags", REG_FLAGS);
      read_back("alu no flags", REG_B);
    end
    run_uop("const one", REG_ONE, REG_TEMPA, INC_NONE, 8'h00);
    read_back("const one", REG_TEMPA);

    // Moves through the pair view
    for (int k = 0; k < PAIR_ROUNDS; k++) begin
      r = rand_bits(8);
      run_uop($sformatf("pair %h", r), REG_IMM_SRC, REG_IMM_DST, INC_NONE, r);
      read_back($sformatf("pair %h", r), REG_A);
      read_back($sformatf("pair %h", r), REG_B);
    end

    @(posedge clk);
    cycle <= CYC_NONE;
    repeat (3) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- regs_top.sv
`timescale 1ns/1ps

module regs_top #(
  parameter logic [regfile_pkg::SP_W-1:0] SP_RESET = 8'h00
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  microcode_pkg::cycle_t             cycle,
  input  microcode_pkg::reg_sel_t           src_sel,
  input  microcode_pkg::reg_sel_t           dst_sel,
  input  microcode_pkg::inc_sel_t           inc_sel,
  input  logic [regfile_pkg::NIBBLE_W-1:0]  alu_result,
  input  logic                              alu_zero,
  input  logic                              alu_carry,
  input  logic [7:0]                        immed,
  input  logic [regfile_pkg::NIBBLE_W-1:0]  mem_rdata,
  output logic [regfile_pkg::ADDR_W-1:0]    mem_addr,
  output logic                              mem_we,
  output logic [regfile_pkg::NIBBLE_W-1:0]  mem_wdata
);

  // Register state shared by the mux and the address unit
  logic [regfile_pkg::NIBBLE_W-1:0] a;
  logic [regfile_pkg::NIBBLE_W-1:0] b;
  logic [regfile_pkg::NIBBLE_W-1:0] temp_a;
  logic [regfile_pkg::NIBBLE_W-1:0] temp_b;
  logic [regfile_pkg::ADDR_W-1:0]   x;
  logic [regfile_pkg::ADDR_W-1:0]   y;
  logic [regfile_pkg::SP_W-1:0]     sp;
  logic [regfile_pkg::NIBBLE_W-1:0] flags;

  logic [regfile_pkg::NIBBLE_W-1:0] bus_data;
  logic                             bus_alu_flags;

  bus_source_mux u_bus_source_mux (
    .clk           (clk),
    .rst_n         (rst_n),
    .cycle         (cycle),
    .src_sel       (src_sel),
    .immed         (immed),
    .alu_result    (alu_result),
    .mem_rdata     (mem_rdata),
    .a             (a),
    .b             (b),
    .temp_a        (temp_a),
    .temp_b        (temp_b),
    .x             (x),
    .y             (y),
    .sp            (sp),
    .flags         (flags),
    .bus_data      (bus_data),
    .bus_alu_flags (bus_alu_flags)
  );

  mem_addr_unit u_mem_addr_unit (
    .src_sel  (src_sel),
    .dst_sel  (dst_sel),
    .immed    (immed),
    .x        (x),
    .y        (y),
    .sp       (sp),
    .mem_addr (mem_addr)
  );

  reg_bank #(
    .SP_RESET (SP_RESET)
  ) u_reg_bank (
    .clk           (clk),
    .rst_n         (rst_n),
    .cycle         (cycle),
    .src_sel       (src_sel),
    .dst_sel       (dst_sel),
    .inc_sel       (inc_sel),
    .immed         (immed),
    .bus_data      (bus_data),
    .bus_alu_flags (bus_alu_flags),
    .alu_zero      (alu_zero),
    .alu_carry     (alu_carry),
    .a             (a),
    .b             (b),
    .temp_a        (temp_a),
    .temp_b        (temp_b),
    .x             (x),
    .y             (y),
    .sp            (sp),
    .flags         (flags),
    .mem_we        (mem_we),
    .mem_wdata     (mem_wdata)
  );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the register section testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module regs_tb -f src.f

out=$(./obj_dir/Vregs_tb)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

//--- src.f
microcode_pkg.sv
regfile_pkg.sv
bus_source_mux.sv
mem_addr_unit.sv
reg_bank.sv
regs_top.sv
tb_clock_gen.sv
regs_tb.sv

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset held low for a fixed number of rising edges
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule
